// ==== Bender.yml ====
package:
  name: rename_core

sources:
  - files:
      - rtl/uopPkg.sv
      - rtl/renamePkg.sv
      - rtl/renameTable.sv
      - rtl/tagFreeList.sv
      - rtl/renameStage.sv
      - rtl/renameCore.sv
  - target: test
    files:
      - bench/renameCore_asserts.sv
      - bench/renameTb.sv

// ==== bench/renameCore_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module renameCore_asserts import renamePkg::*; (
    input wire clk,
    input wire rst,
    input wire inValid,
    input wire inReady,
    input wire outValid,
    input wire allocReq,
    input wire allocOk,
    input wire mispred,
    input wire fillState_t fillState
);

    // read by the testbench at the end of the run
    int failCount = 0;

    // the renamed micro-op shows up exactly one cycle after its transfer
    assert property (@(posedge clk) disable iff (rst) (inValid && inReady) |=> outValid)
        else begin
            failCount++;
            $error("outValid missing one cycle after a transfer");
        end

    assert property (@(posedge clk) disable iff (rst) !(inValid && inReady) |=> !outValid)
        else begin
            failCount++;
            $error("outValid raised without a transfer in the previous cycle");
        end

    assert property (@(posedge clk) disable iff (rst) allocReq |-> allocOk)
        else begin
            failCount++;
            $error("tag allocated from an empty free list");
        end

    assert property (@(posedge clk) disable iff (rst) (fillState == FILL_TAGS) |-> !inReady)
        else begin
            failCount++;
            $error("inReady high while the free list is still filling");
        end

    assert property (@(posedge clk) disable iff (rst) mispred |-> !inReady)
        else begin
            failCount++;
            $error("inReady high in a mispredict cycle");
        end

endmodule

bind renameCore renameCore_asserts u_asserts (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .inReady(inReady),
    .outValid(outValid),
    .allocReq(allocReq),
    .allocOk(allocOk),
    .mispred(mispred),
    .fillState(u_freeList.fillState)
);

`default_nettype wire

// ==== bench/renameTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module renameTb import uopPkg::*; ();

    localparam int NUM_REGS = 32;
    localparam int TAG_SIZE = 7;
    localparam int NUM_TAGS = 1 << (TAG_SIZE - 1);
    localparam int TIMEOUT = 200;

    logic clk;
    logic rst;
    logic inValid;
    logic inReady;
    uopOp_t inOp;
    logic [REG_ID_BITS-1:0] inDest;
    logic [REG_ID_BITS-1:0] inSrcA;
    logic [REG_ID_BITS-1:0] inSrcB;
    logic outValid;
    uopOp_t outOp;
    logic [TAG_SIZE-1:0] outDestTag;
    logic [TAG_SIZE-1:0] outPrevTag;
    logic [TAG_SIZE-1:0] outSrcATag;
    logic outSrcAAvail;
    logic [TAG_SIZE-1:0] outSrcBTag;
    logic outSrcBAvail;
    logic wbValid;
    logic [TAG_SIZE-1:0] wbTag;
    logic commitValid;
    logic [REG_ID_BITS-1:0] commitReg;
    logic [TAG_SIZE-1:0] commitTag;
    logic mispred;

    renameCore #(
        .NUM_REGS(NUM_REGS),
        .TAG_SIZE(TAG_SIZE)
    ) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            stopRun("a DUT output did not match the trace");
        end
    endtask

    // a failed concurrent assertion ends the run at the next falling edge
    always @(negedge clk) begin
        if (u_dut.u_asserts.failCount != 0) begin
            stopRun("a concurrent assertion failed");
        end
    end

    task automatic idleGap();
        repeat ($urandom % 3) @(posedge clk);
    endtask

    // holds the micro-op until it is accepted, then checks the output pulse
    task automatic sendUop(input int op, input int dest, input int srcA, input int srcB,
                           input int wbOn, input int wbT);
        int waited;
        waited = 0;
        @(posedge clk);
        inValid <= 1'b1;
        inOp <= uopOp_t'(op);
        inDest <= dest[REG_ID_BITS-1:0];
        inSrcA <= srcA[REG_ID_BITS-1:0];
        inSrcB <= srcB[REG_ID_BITS-1:0];
        wbValid <= wbOn[0];
        wbTag <= wbT[TAG_SIZE-1:0];
        @(negedge clk);
        while (!inReady) begin
            waited++;
            if (waited > TIMEOUT) begin
                stopRun("timed out waiting for the micro-op to be accepted");
            end
            @(negedge clk);
        end
        @(posedge clk);
        inValid <= 1'b0;
        inOp <= OP_NOP;
        wbValid <= 1'b0;
        @(negedge clk);
        checkValue("outValid", outValid, 1);
    endtask

    task automatic waitReady(input int minLow);
        int lowCycles;
        lowCycles = 0;
        @(negedge clk);
        while (!inReady) begin
            lowCycles++;
            if (lowCycles > TIMEOUT) begin
                stopRun("timed out waiting for inReady");
            end
            @(negedge clk);
        end
        checkValue("inReady low cycles >= minimum", lowCycles >= minLow, 1);
    endtask

    // an op that must stay blocked for the given number of cycles
    task automatic expectStall(input int op, input int dest, input int cycles);
        @(posedge clk);
        inValid <= 1'b1;
        inOp <= uopOp_t'(op);
        inDest <= dest[REG_ID_BITS-1:0];
        inSrcA <= '0;
        inSrcB <= '0;
        repeat (cycles) begin
            @(negedge clk);
            checkValue("inReady", inReady, 0);
        end
        @(posedge clk);
        inValid <= 1'b0;
        inOp <= OP_NOP;
    endtask

    initial begin
        string line;
        int fd;
        int fields;
        int seedInit;
        int op, dest, srcA, srcB, wbOn, wbT;
        int expDest, expPrev, expA, expAv, expB, expBv;

        seedInit = $urandom(13172);
        rst = 1'b1;
        inValid = 1'b0;
        inOp = OP_NOP;
        inDest = '0;
        inSrcA = '0;
        inSrcB = '0;
        wbValid = 1'b0;
        wbTag = '0;
        commitValid = 1'b0;
        commitReg = '0;
        commitTag = '0;
        mispred = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("bench/rename_trace.txt", "r");
        if (fd == 0) begin
            stopRun("could not open the trace file bench/rename_trace.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            fields = $fgets(line, fd);
            if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") begin
                continue;
            end
            idleGap();
            case (line.getc(0))
                "R": begin
                    fields = $sscanf(line, "R %h %h %h %h %h %h %h %h %h %h %h %h",
                        op, dest, srcA, srcB, wbOn, wbT,
                        expDest, expPrev, expA, expAv, expB, expBv);
                    if (fields != 12) begin
                        stopRun({"malformed rename line in the trace: ", line});
                    end
                    sendUop(op, dest, srcA, srcB, wbOn, wbT);
                    checkValue("outOp", outOp, op);
                    checkValue("outDestTag", outDestTag, expDest);
                    checkValue("outPrevTag", outPrevTag, expPrev);
                    checkValue("outSrcATag", outSrcATag, expA);
                    checkValue("outSrcAAvail", outSrcAAvail, expAv);
                    checkValue("outSrcBTag", outSrcBTag, expB);
                    checkValue("outSrcBAvail", outSrcBAvail, expBv);
                end
                "B": begin
                    // count renames of one register, tags handed out in queue order
                    fields = $sscanf(line, "B %h %h %h", op, dest, expDest);
                    for (int i = 0; i < op; i++) begin
                        sendUop(OP_ALU, dest, 0, 0, 0, 0);
                        checkValue("outDestTag", outDestTag, (expDest + i) & (NUM_TAGS - 1));
                    end
                end
                "W": begin
                    fields = $sscanf(line, "W %h", wbT);
                    @(posedge clk);
                    wbValid <= 1'b1;
                    wbTag <= wbT[TAG_SIZE-1:0];
                    @(posedge clk);
                    wbValid <= 1'b0;
                end
                "C": begin
                    fields = $sscanf(line, "C %h %h", dest, wbT);
                    @(posedge clk);
                    commitValid <= 1'b1;
                    commitReg <= dest[REG_ID_BITS-1:0];
                    commitTag <= wbT[TAG_SIZE-1:0];
                    @(posedge clk);
                    commitValid <= 1'b0;
                end
                "M": begin
                    @(posedge clk);
                    mispred <= 1'b1;
                    @(negedge clk);
                    checkValue("inReady", inReady, 0);
                    @(posedge clk);
                    mispred <= 1'b0;
                end
                "I": begin
                    fields = $sscanf(line, "I %h", op);
                    waitReady(op);
                end
                "S": begin
                    fields = $sscanf(line, "S %h %h %h", op, dest, srcA);
                    expectStall(op, dest, srcA);
                end
                default: begin
                    stopRun({"unknown command in the trace: ", line});
                end
            endcase
        end
        $fclose(fd);

        repeat (2) @(negedge clk);
        if (u_dut.u_asserts.failCount != 0) begin
            $display("one or more concurrent assertions failed during the run");
            $display("Simulation failed");
            $fatal(1, "run ended with assertion failures");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== bench/rename_trace.txt ====
# R op dest srcA srcB wbValid wbTag destTag prevTag srcATag srcAAvail srcBTag srcBAvail (hex)
# W tag, C reg tag, M, I minLowCycles, B count dest firstTag, S op dest cycles
I 38
R 1 01 02 03 0 00 00 40 40 1 40 1
R 1 02 01 00 0 00 01 40 00 0 40 1
R 1 03 01 02 1 00 02 40 00 1 01 0
R 2 00 01 03 0 00 40 40 00 1 02 0
R 0 05 01 02 0 00 40 40 40 1 40 1
R 1 00 01 02 0 00 40 40 00 1 01 0
R 1 01 01 00 0 00 03 00 00 1 40 1
C 01 00
C 02 01
M
R 1 03 01 03 0 00 02 40 00 1 40 1
R 1 04 02 01 0 00 03 40 01 0 00 1
W 01
R 1 01 02 04 0 00 04 00 01 1 03 0
C 03 02
C 04 03
C 01 04
B 3b 05 05
R 1 06 05 01 0 00 00 40 3f 0 04 0
S 1 07 4
R 2 00 06 00 0 00 40 40 00 0 40 1

// ==== flist.f ====
rtl/uopPkg.sv
rtl/renamePkg.sv
rtl/renameTable.sv
rtl/tagFreeList.sv
rtl/renameStage.sv
rtl/renameCore.sv
bench/renameCore_asserts.sv
bench/renameTb.sv

// ==== rtl/renameCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module renameCore import uopPkg::*; import renamePkg::*; #(
    parameter int NUM_REGS = 32,
    parameter int TAG_SIZE = 7
) (
    input wire clk,
    input wire rst,

    input wire inValid,
    output logic inReady,
    input wire uopOp_t inOp,
    input wire [REG_ID_BITS-1:0] inDest,
    input wire [REG_ID_BITS-1:0] inSrcA,
    input wire [REG_ID_BITS-1:0] inSrcB,

    output logic outValid,
    output uopOp_t outOp,
    output logic [TAG_SIZE-1:0] outDestTag,
    output logic [TAG_SIZE-1:0] outPrevTag,
    output logic [TAG_SIZE-1:0] outSrcATag,
    output logic outSrcAAvail,
    output logic [TAG_SIZE-1:0] outSrcBTag,
    output logic outSrcBAvail,

    input wire wbValid,
    input wire [TAG_SIZE-1:0] wbTag,

    input wire commitValid,
    input wire [REG_ID_BITS-1:0] commitReg,
    input wire [TAG_SIZE-1:0] commitTag,

    input wire mispred
);

    logic [REG_ID_BITS-1:0] lookupRegA;
    logic [REG_ID_BITS-1:0] lookupRegB;
    logic [REG_ID_BITS-1:0] lookupRegD;
    logic [TAG_SIZE-1:0] lookupTagA;
    logic lookupAvailA;
    logic [TAG_SIZE-1:0] lookupTagB;
    logic lookupAvailB;
    logic [TAG_SIZE-1:0] prevTag;
    logic allocReq;
    logic [TAG_SIZE-1:0] allocTag;
    logic allocOk;
    logic issueValid;
    logic [REG_ID_BITS-1:0] issueReg;
    logic [TAG_SIZE-1:0] issueTag;
    logic [TAG_SIZE-1:0] commitPrevTag;
    logic freeValid;

    // an architectural previous tag was never taken from the free list
    assign freeValid = commitValid && !isArchTag(32'(commitPrevTag), TAG_SIZE);

    renameStage #(
        .NUM_REGS(NUM_REGS),
        .TAG_SIZE(TAG_SIZE)
    ) u_stage (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inReady(inReady),
        .inOp(inOp),
        .inDest(inDest),
        .inSrcA(inSrcA),
        .inSrcB(inSrcB),
        .mispred(mispred),
        .lookupRegA(lookupRegA),
        .lookupRegB(lookupRegB),
        .lookupRegD(lookupRegD),
        .lookupTagA(lookupTagA),
        .lookupAvailA(lookupAvailA),
        .lookupTagB(lookupTagB),
        .lookupAvailB(lookupAvailB),
        .prevTag(prevTag),
        .allocReq(allocReq),
        .allocTag(allocTag),
        .allocOk(allocOk),
        .issueValid(issueValid),
        .issueReg(issueReg),
        .issueTag(issueTag),
        .outValid(outValid),
        .outOp(outOp),
        .outDestTag(outDestTag),
        .outPrevTag(outPrevTag),
        .outSrcATag(outSrcATag),
        .outSrcAAvail(outSrcAAvail),
        .outSrcBTag(outSrcBTag),
        .outSrcBAvail(outSrcBAvail)
    );

    renameTable #(
        .NUM_REGS(NUM_REGS),
        .TAG_SIZE(TAG_SIZE)
    ) u_table (
        .clk(clk),
        .rst(rst),
        .lookupRegA(lookupRegA),
        .lookupRegB(lookupRegB),
        .lookupRegD(lookupRegD),
        .lookupTagA(lookupTagA),
        .lookupAvailA(lookupAvailA),
        .lookupTagB(lookupTagB),
        .lookupAvailB(lookupAvailB),
        .prevTag(prevTag),
        .issueValid(issueValid),
        .issueReg(issueReg),
        .issueTag(issueTag),
        .commitValid(commitValid),
        .commitReg(commitReg),
        .commitTag(commitTag),
        .commitPrevTag(commitPrevTag),
        .wbValid(wbValid),
        .wbTag(wbTag),
        .mispred(mispred)
    );

    tagFreeList #(
        .TAG_SIZE(TAG_SIZE)
    ) u_freeList (
        .clk(clk),
        .rst(rst),
        .allocReq(allocReq),
        .allocTag(allocTag),
        .allocOk(allocOk),
        .freeValid(freeValid),
        .freeTag(commitPrevTag[TAG_SIZE-2:0]),
        .commitValid(commitValid),
        .mispred(mispred)
    );

endmodule

`default_nettype wire

// ==== rtl/renamePkg.sv ====
`default_nettype none

package renamePkg;

    // a tag is TAG_SIZE bits wide
    // with the top bit set the value lives in the architectural register file
    // and is always available
    // with the top bit clear the low bits name one of 2^(TAG_SIZE-1) physical tags

    // progress of the free list after reset
    typedef enum logic {
        FILL_TAGS = 1'b0,
        FILL_DONE = 1'b1
    } fillState_t;

    // tag held by every map entry after reset
    function automatic int unsigned resetTagValue(int unsigned tagSize);
        return 32'd1 << (tagSize - 1);
    endfunction

    function automatic logic isArchTag(logic [31:0] tag, int unsigned tagSize);
        return tag[tagSize - 1];
    endfunction

endpackage

`default_nettype wire

// ==== rtl/renameStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module renameStage import uopPkg::*; import renamePkg::*; #(
    parameter int NUM_REGS = 32,
    parameter int TAG_SIZE = 7
) (
    input wire clk,
    input wire rst,

    input wire inValid,
    output logic inReady,
    input wire uopOp_t inOp,
    input wire [REG_ID_BITS-1:0] inDest,
    input wire [REG_ID_BITS-1:0] inSrcA,
    input wire [REG_ID_BITS-1:0] inSrcB,
    input wire mispred,

    output logic [REG_ID_BITS-1:0] lookupRegA,
    output logic [REG_ID_BITS-1:0] lookupRegB,
    output logic [REG_ID_BITS-1:0] lookupRegD,
    input wire [TAG_SIZE-1:0] lookupTagA,
    input wire lookupAvailA,
    input wire [TAG_SIZE-1:0] lookupTagB,
    input wire lookupAvailB,
    input wire [TAG_SIZE-1:0] prevTag,

    output logic allocReq,
    input wire [TAG_SIZE-1:0] allocTag,
    input wire allocOk,

    output logic issueValid,
    output logic [REG_ID_BITS-1:0] issueReg,
    output logic [TAG_SIZE-1:0] issueTag,

    output logic outValid,
    output uopOp_t outOp,
    output logic [TAG_SIZE-1:0] outDestTag,
    output logic [TAG_SIZE-1:0] outPrevTag,
    output logic [TAG_SIZE-1:0] outSrcATag,
    output logic outSrcAAvail,
    output logic [TAG_SIZE-1:0] outSrcBTag,
    output logic outSrcBAvail
);

    localparam logic [TAG_SIZE-1:0] ARCH_TAG = TAG_SIZE'(resetTagValue(TAG_SIZE));

    logic needsDest;
    logic usesSrc;
    logic fillDone;
    logic transfer;

    // registers outside the map and register 0 are never renamed
    assign needsDest = (inOp == OP_ALU) && (inDest != '0) && (int'(inDest) < NUM_REGS);
    assign usesSrc = (inOp != OP_NOP);

    // a nop looks up register 0 and so reports available architectural sources
    assign lookupRegA = usesSrc ? inSrcA : '0;
    assign lookupRegB = usesSrc ? inSrcB : '0;
    assign lookupRegD = inDest;

    // allocOk first rises when the free list finishes its fill
    always_ff @(posedge clk) begin
        if (rst) begin
            fillDone <= 1'b0;
        end else if (allocOk) begin
            fillDone <= 1'b1;
        end
    end

    assign inReady = (fillDone || allocOk) && !mispred && (!needsDest || allocOk);
    assign transfer = inValid && inReady;

    assign allocReq = transfer && needsDest;
    assign issueValid = allocReq;
    assign issueReg = inDest;
    assign issueTag = allocTag;

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= transfer;
        end
    end

    always_ff @(posedge clk) begin
        if (transfer) begin
            outOp <= inOp;
            outDestTag <= needsDest ? allocTag : ARCH_TAG;
            outPrevTag <= needsDest ? prevTag : ARCH_TAG;
            outSrcATag <= lookupTagA;
            outSrcAAvail <= lookupAvailA;
            outSrcBTag <= lookupTagB;
            outSrcBAvail <= lookupAvailB;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/renameTable.sv ====
`timescale 1ns/1ps
`default_nettype none

module renameTable import uopPkg::*; import renamePkg::*; #(
    parameter int NUM_REGS = 32,
    parameter int TAG_SIZE = 7
) (
    input wire clk,
    input wire rst,

    input wire [REG_ID_BITS-1:0] lookupRegA,
    input wire [REG_ID_BITS-1:0] lookupRegB,
    input wire [REG_ID_BITS-1:0] lookupRegD,
    output logic [TAG_SIZE-1:0] lookupTagA,
    output logic lookupAvailA,
    output logic [TAG_SIZE-1:0] lookupTagB,
    output logic lookupAvailB,
    output logic [TAG_SIZE-1:0] prevTag,

    input wire issueValid,
    input wire [REG_ID_BITS-1:0] issueReg,
    input wire [TAG_SIZE-1:0] issueTag,

    input wire commitValid,
    input wire [REG_ID_BITS-1:0] commitReg,
    input wire [TAG_SIZE-1:0] commitTag,
    output logic [TAG_SIZE-1:0] commitPrevTag,

    input wire wbValid,
    input wire [TAG_SIZE-1:0] wbTag,

    input wire mispred
);

    localparam int NUM_TAGS = 1 << (TAG_SIZE - 1);
    localparam logic [TAG_SIZE-1:0] ARCH_TAG = TAG_SIZE'(resetTagValue(TAG_SIZE));

    logic [TAG_SIZE-1:0] specTag [NUM_REGS];
    logic [TAG_SIZE-1:0] comTag [NUM_REGS];
    logic [NUM_TAGS-1:0] tagReady;

    // a result written back in this very cycle already counts as available
    function automatic logic tagAvail(logic [TAG_SIZE-1:0] tag);
        return isArchTag(32'(tag), TAG_SIZE) || tagReady[tag[TAG_SIZE-2:0]]
            || (wbValid && wbTag == tag);
    endfunction

    always_comb begin
        lookupTagA = specTag[lookupRegA];
        lookupTagB = specTag[lookupRegB];
        prevTag = specTag[lookupRegD];
        commitPrevTag = comTag[commitReg];
        lookupAvailA = tagAvail(lookupTagA);
        lookupAvailB = tagAvail(lookupTagB);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                specTag[i] <= ARCH_TAG;
                comTag[i] <= ARCH_TAG;
            end
            tagReady <= '1;
        end else begin
            if (wbValid && !isArchTag(32'(wbTag), TAG_SIZE)) begin
                tagReady[wbTag[TAG_SIZE-2:0]] <= 1'b1;
            end

            // a mispredict throws away every uncommitted mapping at once
            if (mispred) begin
                for (int i = 0; i < NUM_REGS; i++) begin
                    specTag[i] <= comTag[i];
                end
            end else if (issueValid && issueReg != '0) begin
                specTag[issueReg] <= issueTag;
                // the new tag holds no result until its writeback
                if (!isArchTag(32'(issueTag), TAG_SIZE)) begin
                    tagReady[issueTag[TAG_SIZE-2:0]] <= 1'b0;
                end
            end

            if (commitValid && commitReg != '0) begin
                comTag[commitReg] <= commitTag;
                // a commit in the mispredict cycle must survive the rollback
                if (mispred) begin
                    specTag[commitReg] <= commitTag;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/tagFreeList.sv ====
`timescale 1ns/1ps
`default_nettype none

module tagFreeList import renamePkg::*; #(
    parameter int TAG_SIZE = 7
) (
    input wire clk,
    input wire rst,

    input wire allocReq,
    output logic [TAG_SIZE-1:0] allocTag,
    output logic allocOk,

    input wire freeValid,
    input wire [TAG_SIZE-2:0] freeTag,

    input wire commitValid,
    input wire mispred
);

    localparam int IDX_BITS = TAG_SIZE - 1;
    localparam int NUM_TAGS = 1 << IDX_BITS;

    fillState_t fillState;
    logic [IDX_BITS-1:0] tagQueue [NUM_TAGS];

    // pointers carry one wrap bit above the queue index
    logic [IDX_BITS:0] tail;
    logic [IDX_BITS:0] specHead;
    logic [IDX_BITS:0] comHead;
    logic [IDX_BITS:0] comHeadNext;

    assign comHeadNext = commitValid ? comHead + 1'b1 : comHead;

    // the list counts as empty until every tag has been loaded
    assign allocOk = (fillState == FILL_DONE) && (specHead != tail);
    assign allocTag = {1'b0, tagQueue[specHead[IDX_BITS-1:0]]};

    always_ff @(posedge clk) begin
        if (rst) begin
            fillState <= FILL_TAGS;
            tail <= '0;
            specHead <= '0;
            comHead <= '0;
        end else begin
            if (fillState == FILL_TAGS) begin
                tail <= tail + 1'b1;
                if (tail[IDX_BITS-1:0] == IDX_BITS'(NUM_TAGS - 1)) begin
                    fillState <= FILL_DONE;
                end
            end else if (freeValid) begin
                tail <= tail + 1'b1;
            end

            comHead <= comHeadNext;

            // rollback lands after any commit of the same cycle
            if (mispred) begin
                specHead <= comHeadNext;
            end else if (allocReq) begin
                specHead <= specHead + 1'b1;
            end
        end
    end

    // during the fill the tail index doubles as the tag being loaded
    always_ff @(posedge clk) begin
        if (fillState == FILL_TAGS) begin
            tagQueue[tail[IDX_BITS-1:0]] <= tail[IDX_BITS-1:0];
        end else if (freeValid) begin
            tagQueue[tail[IDX_BITS-1:0]] <= freeTag;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/uopPkg.sv ====
`default_nettype none

package uopPkg;

    // width of an architectural register index
    // register 0 always reads as the architectural zero and is never renamed
    localparam int REG_ID_BITS = 5;

    // micro-op classes as seen by rename
    typedef enum logic [1:0] {
        // touches no register at all
        OP_NOP   = 2'd0,
        // reads two sources and writes one destination
        OP_ALU   = 2'd1,
        // reads two sources and writes nothing
        OP_STORE = 2'd2
    } uopOp_t;

endpackage

`default_nettype wire
